/* hdl/tlu_pkg.sv */
`default_nettype none

package tlu_pkg;

    localparam int ABUS_WIDTH = 16;
    localparam int DATA_WIDTH = 32;

    // register map
    localparam logic [ABUS_WIDTH-1:0] ADDR_SOFT_RST = 16'd0; // write pulses soft reset
    localparam logic [ABUS_WIDTH-1:0] ADDR_CONF1    = 16'd1; // mode, msb_first
    localparam logic [ABUS_WIDTH-1:0] ADDR_CONF2    = 16'd2; // clock cycles, reset enable, lemo inv
    localparam logic [ABUS_WIDTH-1:0] ADDR_TIMEOUT  = 16'd3;
    localparam logic [ABUS_WIDTH-1:0] ADDR_TRIG_NUM = 16'd8; // 8..11, lsb first
    localparam logic [ABUS_WIDTH-1:0] ADDR_LOST     = 16'd12;

    localparam logic [7:0] VERSION = 8'd1; // read back at address 0

    localparam int TLU_CLK_DIVISOR = 8; // bus clocks per tlu_clock period, even
    localparam int FIFO_DEPTH      = 8;

    typedef enum logic [1:0] {
        MODE_DISABLED         = 2'b00,
        MODE_NO_HANDSHAKE     = 2'b01,
        MODE_SIMPLE_HANDSHAKE = 2'b10,
        MODE_DATA_HANDSHAKE   = 2'b11
    } tlu_mode_e;

    typedef enum logic [1:0] {
        IDLE,
        WAIT_LOW,    // busy high, waiting for the TLU to drop the trigger
        CLOCK_DATA,  // clocking the trigger number out of the TLU
        WRITE
    } hs_state_e;

    typedef struct packed {
        tlu_mode_e  mode;
        logic       msb_first;
        logic       invert_lemo;
        logic       enable_reset;
        logic [4:0] clock_cycles; // 0 means 32
        logic [7:0] low_timeout;  // 0 means wait forever
    } tlu_cfg_t;

    typedef struct packed {
        logic trigger;      // synchronized level of the selected port
        logic trigger_flag; // one cycle on rising edge
        logic reset_flag;   // one cycle on rising edge, only with enable_reset
    } trig_in_t;

    typedef struct packed {
        logic                  strobe;
        logic [DATA_WIDTH-1:0] data;
    } fifo_wr_t;

endpackage

`default_nettype wire

/* hdl/tlu_regs.sv */
`default_nettype none
`timescale 1ns/1ns

module tlu_regs
    import tlu_pkg::*;
(
    input  wire                   BUS_CLK,
    input  wire                   RST,
    input  wire  [ABUS_WIDTH-1:0] bus_add,
    input  wire  [7:0]            bus_data_in,
    input  wire                   bus_wr,
    input  wire                   bus_rd,
    input  wire  [DATA_WIDTH-1:0] trig_count,
    input  wire  [7:0]            lost_count,
    output logic [7:0]            bus_data_out,
    output tlu_cfg_t              cfg,
    output logic                  soft_rst
);

    logic [7:0]            conf1;
    logic [7:0]            conf2;
    logic [7:0]            timeout_reg;
    logic [DATA_WIDTH-1:8] trig_buf; // frozen copy for bytes 9..11
    logic                  rst_all;

    assign rst_all = RST | soft_rst;

    // write to address 0 gives a one cycle reset pulse on the next cycle
    always_ff @(posedge BUS_CLK)
    begin
        if (RST)
            soft_rst <= 1'b0;
        else
            soft_rst <= bus_wr && (bus_add == ADDR_SOFT_RST);
    end

    always_ff @(posedge BUS_CLK)
    begin
        if (rst_all)
        begin
            conf1       <= 8'd0;
            conf2       <= 8'd0;
            timeout_reg <= 8'd0;
        end
        else if (bus_wr)
        begin
            case (bus_add)
                ADDR_CONF1:   conf1       <= bus_data_in;
                ADDR_CONF2:   conf2       <= bus_data_in;
                ADDR_TIMEOUT: timeout_reg <= bus_data_in;
                default:      ;
            endcase
        end
    end

    // reading byte 0 freezes the upper bytes
    always_ff @(posedge BUS_CLK)
    begin
        if (rst_all)
            trig_buf <= '0;
        else if (bus_rd && (bus_add == ADDR_TRIG_NUM))
            trig_buf <= trig_count[DATA_WIDTH-1:8];
    end

    always_ff @(posedge BUS_CLK)
    begin
        if (rst_all)
            bus_data_out <= 8'd0;
        else
        begin
            case (bus_add)
                ADDR_SOFT_RST:         bus_data_out <= VERSION;
                ADDR_CONF1:            bus_data_out <= conf1;
                ADDR_CONF2:            bus_data_out <= conf2;
                ADDR_TIMEOUT:          bus_data_out <= timeout_reg;
                ADDR_TRIG_NUM:         bus_data_out <= trig_count[7:0]; // same value as the snapshot
                ADDR_TRIG_NUM + 16'd1: bus_data_out <= trig_buf[15:8];
                ADDR_TRIG_NUM + 16'd2: bus_data_out <= trig_buf[23:16];
                ADDR_TRIG_NUM + 16'd3: bus_data_out <= trig_buf[31:24];
                ADDR_LOST:             bus_data_out <= lost_count;
                default:               bus_data_out <= 8'd0;
            endcase
        end
    end

    // conf1[7:3] and conf2[7] are spare, kept for readback only
    assign cfg = '{
        mode:         tlu_mode_e'(conf1[1:0]),
        msb_first:    conf1[2],
        invert_lemo:  conf2[6],
        enable_reset: conf2[5],
        clock_cycles: conf2[4:0],
        low_timeout:  timeout_reg
    };

endmodule

`default_nettype wire

/* hdl/tlu_input_select.sv */
`default_nettype none
`timescale 1ns/1ns

module tlu_input_select
    import tlu_pkg::*;
(
    input  wire      BUS_CLK,
    input  wire      RST,
    input  wire      rj45_trigger,
    input  wire      lemo_trigger,
    input  wire      rj45_reset,
    input  wire      lemo_reset,
    input  tlu_cfg_t cfg,
    output logic     rj45_enabled,
    output trig_in_t trig
);

    logic       lemo_trig_mod;
    logic [3:0] sync_q1;
    logic [3:0] sync_q2; // {lemo_reset, rj45_reset, lemo_trigger, rj45_trigger}
    logic       trig_sel;
    logic       rst_sel;
    logic       trig_prev;
    logic       rst_prev;
    logic       trig_flag_q;
    logic       rst_flag_q;

    assign lemo_trig_mod = cfg.invert_lemo ? ~lemo_trigger : lemo_trigger;

    always_ff @(posedge BUS_CLK)
    begin
        if (RST)
        begin
            sync_q1 <= 4'd0;
            sync_q2 <= 4'd0;
        end
        else
        begin
            sync_q1 <= {lemo_reset, rj45_reset, lemo_trig_mod, rj45_trigger};
            sync_q2 <= sync_q1;
        end
    end

    // unplugged RJ45 reads high on both lines
    always_ff @(posedge BUS_CLK)
    begin
        if (RST)
            rj45_enabled <= 1'b0;
        else if (cfg.mode == MODE_DISABLED)
            rj45_enabled <= 1'b0;
        else if (sync_q2[0] && sync_q2[2] && !rj45_enabled)
            rj45_enabled <= 1'b0;
        else
            rj45_enabled <= 1'b1;
    end

    assign trig_sel = rj45_enabled ? sync_q2[0] : sync_q2[1];
    assign rst_sel  = rj45_enabled ? sync_q2[2] : sync_q2[3];

    always_ff @(posedge BUS_CLK)
    begin
        if (RST)
        begin
            trig_prev   <= 1'b0;
            rst_prev    <= 1'b0;
            trig_flag_q <= 1'b0;
            rst_flag_q  <= 1'b0;
        end
        else
        begin
            trig_prev   <= trig_sel;
            rst_prev    <= rst_sel;
            trig_flag_q <= trig_sel & ~trig_prev;
            rst_flag_q  <= rst_sel & ~rst_prev & cfg.enable_reset;
        end
    end

    assign trig = '{trigger: trig_sel, trigger_flag: trig_flag_q, reset_flag: rst_flag_q};

endmodule

`default_nettype wire

/* hdl/tlu_handshake_fsm.sv */
`default_nettype none
`timescale 1ns/1ns

module tlu_handshake_fsm
    import tlu_pkg::*;
(
    input  wire                  BUS_CLK,
    input  wire                  RST,
    input  tlu_cfg_t             cfg,
    input  trig_in_t             trig,
    input  wire [DATA_WIDTH-1:0] trig_count,
    output logic                 tlu_busy,
    output logic                 tlu_clock,
    output fifo_wr_t             fifo_wr
);

    localparam int HALF_PERIOD = TLU_CLK_DIVISOR / 2;
    localparam int CNT_W       = (HALF_PERIOD > 1) ? $clog2(HALF_PERIOD) : 1;

    hs_state_e             state;
    logic [CNT_W-1:0]      clk_cnt;   // bus clocks within half a tlu_clock period
    logic [5:0]            bit_cnt;   // falling edges seen so far
    logic [5:0]            num_bits;
    logic [5:0]            bit_idx;
    logic [7:0]            low_cnt;
    logic [DATA_WIDTH-1:0] tlu_number;
    logic [DATA_WIDTH-1:0] trig_number;
    logic                  half_done;
    logic                  falling;
    logic                  timed_out;

    assign num_bits  = (cfg.clock_cycles == 5'd0) ? 6'd32 : {1'b0, cfg.clock_cycles};
    assign bit_idx   = cfg.msb_first ? (num_bits - 6'd1 - bit_cnt) : bit_cnt;
    assign half_done = (clk_cnt == CNT_W'(HALF_PERIOD - 1));
    assign falling   = half_done && tlu_clock; // tlu_clock about to go low
    assign timed_out = (cfg.low_timeout != 8'd0) && (low_cnt == cfg.low_timeout - 8'd1);

    always_ff @(posedge BUS_CLK)
    begin
        if (RST)
        begin
            state     <= IDLE;
            tlu_clock <= 1'b0;
            clk_cnt   <= '0;
            bit_cnt   <= 6'd0;
            low_cnt   <= 8'd0;
        end
        else
        begin
            case (state)
                IDLE:
                begin
                    tlu_clock <= 1'b0;
                    clk_cnt   <= '0;
                    bit_cnt   <= 6'd0;
                    low_cnt   <= 8'd0;
                    if (trig.trigger_flag)
                    begin
                        case (cfg.mode)
                            MODE_NO_HANDSHAKE:     state <= WRITE;
                            MODE_SIMPLE_HANDSHAKE: state <= WAIT_LOW;
                            MODE_DATA_HANDSHAKE:   state <= WAIT_LOW;
                            default:               state <= IDLE; // disabled
                        endcase
                    end
                end

                WAIT_LOW:
                begin
                    if (!trig.trigger)
                    begin
                        if (cfg.mode == MODE_DATA_HANDSHAKE)
                            state <= CLOCK_DATA;
                        else
                            state <= WRITE;
                    end
                    else if (timed_out)
                        state <= IDLE; // TLU never answered, drop the event
                    else
                        low_cnt <= low_cnt + 8'd1;
                end

                CLOCK_DATA:
                begin
                    if (half_done)
                    begin
                        clk_cnt   <= '0;
                        tlu_clock <= ~tlu_clock;
                        if (tlu_clock)
                        begin
                            bit_cnt <= bit_cnt + 6'd1;
                            if (bit_cnt == num_bits - 6'd1)
                                state <= WRITE;
                        end
                    end
                    else
                        clk_cnt <= clk_cnt + CNT_W'(1);
                end

                WRITE:
                    state <= IDLE;

                default:
                    state <= IDLE;
            endcase
        end
    end

    // number bits land at their final position, upper bits stay zero
    always_ff @(posedge BUS_CLK)
    begin
        if (state == IDLE)
            tlu_number <= '0;
        else if ((state == CLOCK_DATA) && falling)
            tlu_number[bit_idx[4:0]] <= trig.trigger;
    end

    // counter still holds the pre-increment value during WRITE
    assign trig_number = (cfg.mode == MODE_DATA_HANDSHAKE) ? tlu_number : trig_count;

    assign tlu_busy = (state == WAIT_LOW) || (state == CLOCK_DATA);

    assign fifo_wr = '{
        strobe: (state == WRITE),
        data:   {1'b1, trig_number[DATA_WIDTH-2:0]}
    };

endmodule

`default_nettype wire

/* hdl/tlu_event_fifo.sv */
`default_nettype none
`timescale 1ns/1ns

module tlu_event_fifo
    import tlu_pkg::*;
(
    input  wire                   BUS_CLK,
    input  wire                   RST,
    input  fifo_wr_t              fifo_wr,
    input  wire                   fifo_read,
    output logic                  fifo_empty,
    output logic [DATA_WIDTH-1:0] fifo_data,
    output logic [7:0]            lost_count
);

    localparam int PTR_W = $clog2(FIFO_DEPTH);

    logic [DATA_WIDTH-1:0] mem [FIFO_DEPTH];
    logic [PTR_W:0]        wr_ptr; // extra msb tells full from empty
    logic [PTR_W:0]        rd_ptr;
    logic                  full;
    logic                  do_write;
    logic                  do_read;

    assign full = (wr_ptr[PTR_W] != rd_ptr[PTR_W])
               && (wr_ptr[PTR_W-1:0] == rd_ptr[PTR_W-1:0]);
    assign fifo_empty = (wr_ptr == rd_ptr);

    assign do_write = fifo_wr.strobe && !full;
    assign do_read  = fifo_read && !fifo_empty; // pop on empty is ignored

    always_ff @(posedge BUS_CLK)
    begin
        if (do_write)
            mem[wr_ptr[PTR_W-1:0]] <= fifo_wr.data;
    end

    assign fifo_data = mem[rd_ptr[PTR_W-1:0]]; // show-ahead

    always_ff @(posedge BUS_CLK)
    begin
        if (RST)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end
        else
        begin
            if (do_write)
                wr_ptr <= wr_ptr + (PTR_W+1)'(1);
            if (do_read)
                rd_ptr <= rd_ptr + (PTR_W+1)'(1);
        end
    end

    // saturates at 255
    always_ff @(posedge BUS_CLK)
    begin
        if (RST)
            lost_count <= 8'd0;
        else if (fifo_wr.strobe && full && (lost_count != 8'hff))
            lost_count <= lost_count + 8'd1;
    end

endmodule

`default_nettype wire

/* hdl/tlu_controller.sv */
`default_nettype none
`timescale 1ns/1ns

module tlu_controller
    import tlu_pkg::*;
(
    input  wire                   BUS_CLK,
    input  wire                   RST,
    input  wire  [ABUS_WIDTH-1:0] bus_add,
    input  wire  [7:0]            bus_data_in,
    input  wire                   bus_wr,
    input  wire                   bus_rd,
    output logic [7:0]            bus_data_out,
    input  wire                   rj45_trigger,
    input  wire                   lemo_trigger,
    input  wire                   rj45_reset,
    input  wire                   lemo_reset,
    output logic                  rj45_enabled,
    output logic                  tlu_busy,
    output logic                  tlu_clock,
    input  wire                   fifo_read,
    output logic                  fifo_empty,
    output logic [DATA_WIDTH-1:0] fifo_data,
    output logic [DATA_WIDTH-1:0] timestamp
);

    tlu_cfg_t              cfg;
    trig_in_t              trig;
    fifo_wr_t              fifo_wr;
    logic                  soft_rst;
    logic                  rst_all;
    logic [DATA_WIDTH-1:0] trig_count;
    logic [7:0]            lost_count;

    assign rst_all = RST | soft_rst;

    always_ff @(posedge BUS_CLK)
    begin
        if (rst_all || trig.reset_flag)
            timestamp <= '0;
        else
            timestamp <= timestamp + DATA_WIDTH'(1);
    end

    // accepted triggers, one per FIFO strobe
    always_ff @(posedge BUS_CLK)
    begin
        if (rst_all || trig.reset_flag)
            trig_count <= '0;
        else if (fifo_wr.strobe && (trig_count != '1))
            trig_count <= trig_count + DATA_WIDTH'(1);
    end

    tlu_regs u_regs (
        .BUS_CLK, .RST, .bus_add, .bus_data_in, .bus_wr, .bus_rd,
        .trig_count, .lost_count, .bus_data_out, .cfg, .soft_rst
    );

    tlu_input_select u_input_select (
        .BUS_CLK, .RST(rst_all), .rj45_trigger, .lemo_trigger, .rj45_reset,
        .lemo_reset, .cfg, .rj45_enabled, .trig
    );

    tlu_handshake_fsm u_handshake_fsm (
        .BUS_CLK, .RST(rst_all), .cfg, .trig, .trig_count,
        .tlu_busy, .tlu_clock, .fifo_wr
    );

    tlu_event_fifo u_event_fifo (
        .BUS_CLK, .RST(rst_all), .fifo_wr, .fifo_read,
        .fifo_empty, .fifo_data, .lost_count
    );

endmodule

`default_nettype wire

/* dv/tb_clock_gen.sv */
`default_nettype none
`timescale 1ns/1ns

module tb_clock_gen #(
    parameter int PERIOD     = 20,
    parameter int RST_CYCLES = 4
)
(
    output logic BUS_CLK,
    output logic RST
);

    initial
    begin
        BUS_CLK = 1'b0;
        forever #(PERIOD / 2) BUS_CLK = ~BUS_CLK;
    end

    // release just after an edge, like the other stimulus
    initial
    begin
        RST = 1'b1;
        repeat (RST_CYCLES) @(posedge BUS_CLK);
        #2;
        RST = 1'b0;
    end

endmodule

`default_nettype wire

/* dv/tlu_tb.sv */
`default_nettype none
`timescale 1ns/1ns

module tlu_tb;

    localparam int CLK_PERIOD  = 20;
    localparam int WAIT_LIMIT  = 64;   // cycles allowed for one handshake step
    localparam int EST_CYCLES  = 1000; // all tests together take about 800 cycles
    localparam int WATCHDOG_NS = 10 * EST_CYCLES * CLK_PERIOD; // 200 us

    localparam logic [15:0] A_SOFT_RST = 16'd0;
    localparam logic [15:0] A_CONF1    = 16'd1;
    localparam logic [15:0] A_CONF2    = 16'd2;
    localparam logic [15:0] A_TIMEOUT  = 16'd3;
    localparam logic [15:0] A_TRIG_NUM = 16'd8;
    localparam logic [15:0] A_LOST     = 16'd12;

    localparam logic [7:0] EXP_VERSION = 8'h01;
    localparam int         FIFO_WORDS  = 8;
    localparam int         N_TRIG      = 5;
    localparam int         N_OVER      = 11; // three more than the FIFO holds

    logic        BUS_CLK;
    logic        RST;
    logic [15:0] bus_add;
    logic [7:0]  bus_data_in;
    logic        bus_wr;
    logic        bus_rd;
    logic [7:0]  bus_data_out;
    logic        rj45_trigger;
    logic        lemo_trigger;
    logic        rj45_reset;
    logic        lemo_reset;
    logic        rj45_enabled;
    logic        tlu_busy;
    logic        tlu_clock;
    logic        fifo_read;
    logic        fifo_empty;
    logic [31:0] fifo_data;
    logic [31:0] timestamp;

    int     errors      = 0;
    int     prop_errors = 0;
    int     checks      = 0;
    integer seed        = 30;

    tb_clock_gen #(.PERIOD(CLK_PERIOD), .RST_CYCLES(4)) u_clock_gen (.BUS_CLK, .RST);

    tlu_controller UUT (
        .BUS_CLK, .RST, .bus_add, .bus_data_in, .bus_wr, .bus_rd, .bus_data_out,
        .rj45_trigger, .lemo_trigger, .rj45_reset, .lemo_reset,
        .rj45_enabled, .tlu_busy, .tlu_clock,
        .fifo_read, .fifo_empty, .fifo_data, .timestamp
    );

    // tlu_clock only runs inside a handshake
    assert property (@(posedge BUS_CLK) disable iff (RST) (!tlu_clock || tlu_busy))
    else
    begin
        prop_errors++;
        $display("** Error: tlu_busy = 0x%0h while tlu_clock = 0x%0h", tlu_busy, tlu_clock);
    end

    // both rj45 lines sit high, so no cable is seen
    assert property (@(posedge BUS_CLK) disable iff (RST) !rj45_enabled)
    else
    begin
        prop_errors++;
        $display("** Error: rj45_enabled = 0x%0h, expected 0x0", rj45_enabled);
    end

    task automatic byte_equals(input string name, input logic [7:0] got, input logic [7:0] exp);
        checks++;
        assert (got === exp)
        else
        begin
            errors++;
            $display("** Error: %s = 0x%0h, expected 0x%0h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic word_equals(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        assert (got === exp)
        else
        begin
            errors++;
            $display("** Error: %s = 0x%0h, expected 0x%0h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic require(input logic cond, input string what);
        checks++;
        assert (cond === 1'b1)
        else
        begin
            errors++;
            $display("check failed at %0t: %s", $time, what);
        end
    endtask

    task automatic write_reg(input logic [15:0] addr, input logic [7:0] data);
        @(posedge BUS_CLK);
        #2;
        bus_add     = addr;
        bus_data_in = data;
        bus_wr      = 1'b1;
        @(posedge BUS_CLK);
        #2;
        bus_wr = 1'b0;
    endtask

    // data comes back one cycle after the address
    task automatic read_reg(input logic [15:0] addr, output logic [7:0] data);
        @(posedge BUS_CLK);
        #2;
        bus_add = addr;
        bus_rd  = 1'b1;
        @(posedge BUS_CLK);
        #2;
        bus_rd = 1'b0;
        data   = bus_data_out;
    endtask

    task automatic fetch_trig_count(output logic [31:0] value);
        logic [7:0] b;
        for (int i = 0; i < 4; i++)
        begin
            read_reg(A_TRIG_NUM + 16'(i), b); // byte 0 first, it freezes the rest
            value[8*i +: 8] = b;
        end
    endtask

    task automatic apply_soft_reset();
        write_reg(A_SOFT_RST, 8'h00);
        repeat (2) @(posedge BUS_CLK);
        #2;
    endtask

    task automatic configure(input logic [7:0] conf1, input logic [7:0] conf2,
                             input logic [7:0] timeout);
        write_reg(A_TIMEOUT, timeout);
        write_reg(A_CONF2, conf2);
        write_reg(A_CONF1, conf1); // mode last
    endtask

    task automatic pulse_trigger();
        @(posedge BUS_CLK);
        #2;
        lemo_trigger = 1'b1;
        repeat (2) @(posedge BUS_CLK);
        #2;
        lemo_trigger = 1'b0;
        repeat (6) @(posedge BUS_CLK);
        #2;
    endtask

    task automatic wait_busy(input logic level, input string what);
        int n = 0;
        while ((tlu_busy !== level) && (n < WAIT_LIMIT))
        begin
            @(posedge BUS_CLK);
            #2;
            n++;
        end
        require(tlu_busy === level, what);
    endtask

    task automatic follow_tlu_clock(input logic level);
        int n = 0;
        while ((tlu_clock !== level) && (n < WAIT_LIMIT))
        begin
            @(posedge BUS_CLK);
            #2;
            n++;
        end
        require(tlu_clock === level, "tlu_clock stopped toggling during the data phase");
    endtask

    task automatic await_fifo_word();
        int n = 0;
        while (fifo_empty && (n < WAIT_LIMIT))
        begin
            @(posedge BUS_CLK);
            #2;
            n++;
        end
        require(!fifo_empty, "no word arrived in the FIFO");
    endtask

    task automatic pop_word(output logic [31:0] word);
        await_fifo_word();
        word      = fifo_data; // show-ahead
        fifo_read = 1'b1;
        @(posedge BUS_CLK);
        #2;
        fifo_read = 1'b0;
    endtask

    task automatic register_readback();
        logic [7:0] val;
        write_reg(A_CONF1, 8'hF8); // mode bits left at disabled
        write_reg(A_CONF2, 8'h9A);
        write_reg(A_TIMEOUT, 8'h3C);
        read_reg(A_CONF1, val);
        byte_equals("conf1", val, 8'hF8);
        read_reg(A_CONF2, val);
        byte_equals("conf2", val, 8'h9A);
        read_reg(A_TIMEOUT, val);
        byte_equals("timeout", val, 8'h3C);
        read_reg(A_SOFT_RST, val);
        byte_equals("version", val, EXP_VERSION);
        apply_soft_reset();
        for (int a = 1; a <= 3; a++)
        begin
            read_reg(16'(a), val);
            byte_equals($sformatf("reg[%0d] after soft reset", a), val, 8'h00);
        end
    endtask

    task automatic count_triggers();
        logic [31:0] word;
        logic [31:0] count;
        apply_soft_reset();
        configure(8'h01, 8'h00, 8'h00);
        for (int k = 0; k < N_TRIG; k++)
            pulse_trigger();
        for (int k = 0; k < N_TRIG; k++)
        begin
            pop_word(word);
            word_equals("fifo_data", word, {1'b1, 31'(k)});
        end
        fetch_trig_count(count);
        word_equals("trigger count", count, 32'(N_TRIG));
    endtask

    // TLU side of the data handshake
    task automatic receive_tlu_number(input logic msb);
        logic [31:0] rnd;
        logic [15:0] num;
        logic [31:0] word;
        rnd = $random(seed);
        num = rnd[15:0];
        apply_soft_reset();
        configure({5'd0, msb, 2'b11}, 8'h10, 8'h00); // 16 clock cycles
        @(posedge BUS_CLK);
        #2;
        lemo_trigger = 1'b1;
        wait_busy(1'b1, "tlu_busy never rose in data handshake");
        lemo_trigger = 1'b0;
        for (int i = 0; i < 16; i++)
        begin
            follow_tlu_clock(1'b0);
            follow_tlu_clock(1'b1);
            lemo_trigger = msb ? num[15-i] : num[i]; // settles before the falling edge
        end
        wait_busy(1'b0, "tlu_busy stuck high after the data phase");
        lemo_trigger = 1'b0;
        pop_word(word);
        word_equals("fifo_data", word, {1'b1, 15'd0, num});
        byte_equals("tlu_busy", {7'd0, tlu_busy}, 8'h00);
    endtask

    task automatic trigger_timeout();
        logic [7:0] val;
        apply_soft_reset();
        configure(8'h02, 8'h00, 8'd10);
        @(posedge BUS_CLK);
        #2;
        lemo_trigger = 1'b1; // never answered
        wait_busy(1'b1, "tlu_busy never rose in simple handshake");
        wait_busy(1'b0, "tlu_busy did not drop after the low timeout");
        repeat (20) @(posedge BUS_CLK);
        #2;
        byte_equals("fifo_empty", {7'd0, fifo_empty}, 8'h01);
        byte_equals("tlu_busy", {7'd0, tlu_busy}, 8'h00);
        lemo_trigger = 1'b0;
        repeat (10) @(posedge BUS_CLK);
        #2;
        byte_equals("fifo_empty", {7'd0, fifo_empty}, 8'h01);
        read_reg(A_TRIG_NUM, val);
        byte_equals("trigger count byte 0", val, 8'h00);
    endtask

    task automatic fifo_overflow();
        logic [7:0]  val;
        logic [31:0] word;
        apply_soft_reset();
        configure(8'h01, 8'h00, 8'h00);
        for (int k = 0; k < N_OVER; k++)
            pulse_trigger();
        read_reg(A_LOST, val);
        byte_equals("lost count", val, 8'(N_OVER - FIFO_WORDS));
        for (int k = 0; k < FIFO_WORDS; k++)
        begin
            pop_word(word);
            word_equals("fifo_data", word, {1'b1, 31'(k)});
        end
        byte_equals("fifo_empty", {7'd0, fifo_empty}, 8'h01);
    endtask

    task automatic tlu_reset_input();
        logic [31:0] count;
        logic [31:0] ts_before;
        int          n = 0;
        apply_soft_reset();
        configure(8'h01, 8'h20, 8'h00); // enable_reset
        repeat (3) pulse_trigger();
        fetch_trig_count(count);
        word_equals("trigger count", count, 32'd3);
        ts_before  = timestamp;
        lemo_reset = 1'b1;
        repeat (2) @(posedge BUS_CLK);
        #2;
        lemo_reset = 1'b0;
        while ((timestamp >= ts_before) && (n < WAIT_LIMIT))
        begin
            @(posedge BUS_CLK);
            #2;
            n++;
        end
        require(timestamp < ts_before, "timestamp did not drop after the TLU reset pulse");
        fetch_trig_count(count);
        word_equals("trigger count", count, 32'd0);
    endtask

    initial
    begin
        bus_add      = 16'd0;
        bus_data_in  = 8'd0;
        bus_wr       = 1'b0;
        bus_rd       = 1'b0;
        rj45_trigger = 1'b1; // no cable
        rj45_reset   = 1'b1;
        lemo_trigger = 1'b0;
        lemo_reset   = 1'b0;
        fifo_read    = 1'b0;

        repeat (3) @(posedge BUS_CLK);
        #2;
        byte_equals("bus_data_out", bus_data_out, 8'h00); // RST still high here
        byte_equals("tlu_busy", {7'd0, tlu_busy}, 8'h00);
        byte_equals("tlu_clock", {7'd0, tlu_clock}, 8'h00);
        byte_equals("rj45_enabled", {7'd0, rj45_enabled}, 8'h00);
        byte_equals("fifo_empty", {7'd0, fifo_empty}, 8'h01);
        wait (RST == 1'b0);

        register_readback();
        count_triggers();
        receive_tlu_number(1'b0);
        receive_tlu_number(1'b1);
        trigger_timeout();
        fifo_overflow();
        tlu_reset_input();

        repeat (4) @(posedge BUS_CLK);
        $display("checks %0d, errors %0d, assertion errors %0d",
                 checks, errors + prop_errors, prop_errors);
        if ((errors + prop_errors) == 0)
        begin
            $display("SIMULATION PASSED");
        end
        else
        begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

    initial
    begin
        #(WATCHDOG_NS);
        $display("watchdog expired at %0t, the tests did not finish", $time);
        $display("SIMULATION FAILED");
        $finish;
    end

endmodule

`default_nettype wire

/* all.f */
hdl/tlu_pkg.sv
hdl/tlu_regs.sv
hdl/tlu_input_select.sv
hdl/tlu_handshake_fsm.sv
hdl/tlu_event_fifo.sv
hdl/tlu_controller.sv
dv/tb_clock_gen.sv
dv/tlu_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the TLU controller testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --top-module tlu_tb -f all.f -o tlu_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

sim_out=$(./obj_dir/tlu_sim 2>&1)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if echo "$sim_out" | grep -qx "SIMULATION PASSED"; then
    exit 0
fi
exit 1
